/* Makefile */
TOP  = xnorLayer_tb
SRCS = $(filter %.sv,$(shell cat xnorLayer.f)) xnorLayer_defines.svh

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

obj_dir/V%: $(SRCS) xnorLayer.f
	verilator --binary --timing --assert -Wno-fatal \
		-f xnorLayer.f --top-module $* -o V$*

clean:
	rm -rf obj_dir

/* accumIf.sv */
`timescale 1ns/1ps

interface accumIf;
  import xnorLayerPkg::*;

  // zeroes every match counter.
  logic clear;
  // add the current slot this cycle.
  logic step;
  // nonzero slot being walked.
  slotT slot;
  // high on the final slot of the walk.
  logic lastSlot;

  // sequencer side.
  modport ctrl (output clear, output step, input lastSlot);

  // slot counter side.
  modport count (input clear, input step, output slot, output lastSlot);

  // row accumulators only listen.
  modport accum (input clear, input step, input slot);

endinterface

/* layerControl.sv */
`timescale 1ns/1ps

module layerControl (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  output logic  busy,
  output logic  done,
  accumIf.ctrl  acc
);
  import xnorLayerPkg::*;

  ctrlStateT state;
  ctrlStateT nextState;

  // ********************
  // next state.
  // ********************
  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (start) begin
          nextState = run;
        end
      end
      run: begin
        // the walk ends on the slot that raises lastSlot.
        if (acc.lastSlot) begin
          nextState = finish;
        end
      end
      finish: begin
        // a start in the done cycle is taken right away.
        if (start) begin
          nextState = run;
        end else begin
          nextState = idle;
        end
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  // ********************
  // outputs.
  // ********************
  // a start is only accepted outside the walk.
  assign acc.clear = start && (state != run);
  assign acc.step  = (state == run);

  assign busy = (state == run);
  assign done = (state == finish);

endmodule

/* slotCounter.sv */
`timescale 1ns/1ps

`include "xnorLayer_defines.svh"

module slotCounter (
  input  logic  clk,
  input  logic  rst,
  accumIf.count acc
);
  import xnorLayerPkg::*;

  localparam slotT LAST_SLOT = slotT'(`MAX_LEN - 1);

  // terminal flag comes straight from the count.
  assign acc.lastSlot = (acc.slot == LAST_SLOT);

  // ********************
  // slot index.
  // ********************
  // clear wins over step, so a new walk always begins at slot 0.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc.slot <= '0;
    end else if (acc.clear) begin
      acc.slot <= '0;
    end else if (acc.step && !acc.lastSlot) begin
      acc.slot <= acc.slot + 1'b1;
    end
  end

  // holds at the last slot until the next clear.

endmodule

/* xnorLayer.f */
+incdir+.
xnorLayerPkg.sv
accumIf.sv
layerControl.sv
slotCounter.sv
xnorRowAccum.sv
xnorSparseMatVec.sv
xnorLayerTop.sv
xnorLayer_properties.sv
xnorLayer_tb.sv

/* xnorLayerPkg.sv */
`include "xnorLayer_defines.svh"

package xnorLayerPkg;

  // ********************
  // datapath types.
  // ********************

  // one input vector as captured on start.
  typedef logic [`N_IN-1:0] inVecT;

  // index of the nonzero slot being walked.
  typedef logic [`SLOT_W-1:0] slotT;

  // corrected row score, 2*matches + MAX_LEN - rowLen.
  typedef logic [`SCORE_W-1:0] scoreT;

  // ********************
  // control types.
  // ********************

  // idle waits for start, run walks the slots, finish flags the result.
  typedef enum logic [1:0] {
    idle   = 2'd0,
    run    = 2'd1,
    finish = 2'd2
  } ctrlStateT;

endpackage

/* xnorLayerTop.sv */
`timescale 1ns/1ps

`include "xnorLayer_defines.svh"

module xnorLayerTop (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic [`N_IN-1:0]              inVec,
  output logic                          busy,
  output logic                          done,
  output logic [`M_ROWS*`SCORE_W-1:0]   scores
);
  import xnorLayerPkg::*;

  scoreT rowScores [`M_ROWS];

  // ********************
  // slot-step bus.
  // ********************
  accumIf accBus ();

  layerControl uControl (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .done  (done),
    .acc   (accBus.ctrl)
  );

  slotCounter uCounter (
    .clk (clk),
    .rst (rst),
    .acc (accBus.count)
  );

  xnorSparseMatVec uMatVec (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .inVec  (inVec),
    .acc    (accBus.accum),
    .scores (rowScores)
  );

  // row 0 sits in the low bits.
  for (genvar r = 0; r < `M_ROWS; r++) begin : gFlat
    assign scores[r*`SCORE_W +: `SCORE_W] = rowScores[r];
  end

endmodule

/* xnorLayer_defines.svh */
`ifndef XNORLAYER_DEFINES_SVH
`define XNORLAYER_DEFINES_SVH

// ********************
// layer sizes.
// ********************
`define N_IN     8
`define M_ROWS   4
`define MAX_LEN  4
`define NNZ      10

// slot index and score widths.
`define SLOT_W   ($clog2(`MAX_LEN))
`define SCORE_W  ($clog2(2 * `MAX_LEN + 1))

// ********************
// compressed-row weights.
// ********************
// row 0 has 2 nonzeros, row 1 is empty, rows 2 and 3 hold MAX_LEN each.
// sign bit k belongs to nonzero k, a 1 means a +1 weight.
`define W_SIGNS    10'b10_1100_1101

// input column of each nonzero, byte k for nonzero k.
`define W_COLS     80'h01_06_05_02_07_04_03_00_06_01

// start index of each row, byte M_ROWS closes the last row.
`define W_ROWSTART 40'h0A_06_02_02_00

`endif

/* xnorLayer_properties.sv */
`timescale 1ns/1ps

`include "xnorLayer_defines.svh"

module layerControlProps (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic done
);

  // cycles from an accepted start to its done pulse.
  localparam int DONE_LAT = `MAX_LEN + 1;

  // a start only counts while the walk is not running.
  logic accepted;

  // consecutive cycles with busy high, up to the last edge.
  int busyCycles;

  assign accepted = start && !busy;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busyCycles <= 0;
    end else if (busy) begin
      busyCycles <= busyCycles + 1;
    end else begin
      busyCycles <= 0;
    end
  end

  // ********************
  // control timing.
  // ********************
  doneOneCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done stayed high for more than one cycle");

  doneAfterStart: assert property (
    @(posedge clk) disable iff (rst) done |-> $past(accepted, DONE_LAT))
    else $error("done without an accepted start %0d cycles before", DONE_LAT);

  // busy covers the whole walk and has dropped by the done cycle.
  busyWalkAtDone: assert property (
    @(posedge clk) disable iff (rst) done |-> (!busy && busyCycles == `MAX_LEN))
    else $error("busy was not high for the whole walk or still high at done");

endmodule

bind layerControl layerControlProps uProps (
  .clk   (clk),
  .rst   (rst),
  .start (start),
  .busy  (busy),
  .done  (done)
);

/* xnorLayer_tb.sv */
`timescale 1ns/1ps

`include "xnorLayer_defines.svh"

module xnorLayer_tb;
  import xnorLayerPkg::*;

  localparam int RESET_CYCLES = 10;
  // largest random idle time added on top of a trace gap.
  localparam int MAX_EXTRA = 3;
  localparam logic [(`M_ROWS+1)*8-1:0] ROW_START = `W_ROWSTART;

  logic                        clk;
  logic                        rst;
  logic                        start;
  inVecT                       inVec;
  logic                        busy;
  logic                        done;
  logic [`M_ROWS*`SCORE_W-1:0] scoresFlat;

  inVecT  vecQ[$];
  int     gapQ[$];
  scoreT  expQ[$];
  integer seed = 75;
  int     cycleCount = 0;
  int     cycleLimit = 0;
  int     checkCount = 0;

  xnorLayerTop u_dut (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .inVec  (inVec),
    .busy   (busy),
    .done   (done),
    .scores (scoresFlat)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ********************
  // checks.
  // ********************
  task automatic failAndStop();
    $display("RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkScore(input string testName, input string what,
                            input scoreT expected, input scoreT actual);
    checkCount++;
    if (actual !== expected) begin
      $display("ERR %s %s: expected %0d actual %0d", testName, what, expected, actual);
      failAndStop();
    end
  endtask

  task automatic checkFlag(input string testName, input string what,
                           input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      $display("ERR %s %s: expected %0b actual %0b", testName, what, expected, actual);
      failAndStop();
    end
  endtask

  function automatic int rowLength(input int r);
    return int'(ROW_START[(r+1)*8 +: 8]) - int'(ROW_START[r*8 +: 8]);
  endfunction

  function automatic scoreT rowScore(input int r);
    return scoresFlat[r*`SCORE_W +: `SCORE_W];
  endfunction

  // trace values for every row, and MAX_LEN for the empty ones.
  task automatic checkRows(input string testName, input int idx);
    for (int r = 0; r < `M_ROWS; r++) begin
      checkScore(testName, $sformatf("row %0d", r), expQ[idx*`M_ROWS + r], rowScore(r));
      if (rowLength(r) == 0) begin
        checkScore(testName, $sformatf("empty row %0d", r), scoreT'(`MAX_LEN), rowScore(r));
      end
    end
  endtask

  // ********************
  // trace input.
  // ********************
  task automatic readTrace();
    int    fd;
    int    n;
    int    vRaw;
    int    gRaw;
    int    e0;
    int    e1;
    int    e2;
    int    e3;
    string line;
    fd = $fopen("xnorLayer_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file xnorLayer_trace.txt");
      failAndStop();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (!(line.len() >= 2 && line.substr(0, 1) == "//")) begin
          n = $sscanf(line, "%h %d %d %d %d %d", vRaw, gRaw, e0, e1, e2, e3);
          if (n == 6) begin
            vecQ.push_back(inVecT'(vRaw));
            gapQ.push_back(gRaw);
            expQ.push_back(scoreT'(e0));
            expQ.push_back(scoreT'(e1));
            expQ.push_back(scoreT'(e2));
            expQ.push_back(scoreT'(e3));
          end else if (n > 0) begin
            $display("malformed trace line: %s", line);
            failAndStop();
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ********************
  // one trace vector.
  // ********************
  // called at a falling edge; start is driven right away.
  task automatic runTest(input int idx);
    string testName;
    inVecT vec;
    int    idle;
    vec = vecQ[idx];
    testName = $sformatf("test%0d_vec%02h", idx, vec);
    idle = gapQ[idx] + int'($unsigned($random(seed)) % (MAX_EXTRA + 1));
    start = 1'b1;
    inVec = vec;
    for (int n = 1; n <= `MAX_LEN; n++) begin
      @(negedge clk);
      start = 1'b0;
      inVec = ~vec;
      // every third test tries a second start in the middle of the walk.
      if (n == 2 && idx % 3 == 1) begin
        start = 1'b1;
      end
      checkFlag(testName, $sformatf("busy in cycle %0d", n), 1'b1, busy);
      checkFlag(testName, $sformatf("done in cycle %0d", n), 1'b0, done);
    end
    @(negedge clk);
    checkFlag(testName, "done pulse", 1'b1, done);
    checkFlag(testName, "busy at done", 1'b0, busy);
    checkRows(testName, idx);
    // results hold through the idle gap.
    for (int k = 0; k < idle; k++) begin
      @(negedge clk);
      checkFlag(testName, "done while idle", 1'b0, done);
      checkFlag(testName, "busy while idle", 1'b0, busy);
      checkRows(testName, idx);
    end
  endtask

  // ********************
  // main sequence.
  // ********************
  initial begin
    int maxGap;
    rst = 1'b1;
    start = 1'b0;
    inVec = '0;
    maxGap = 0;
    readTrace();
    foreach (gapQ[i]) begin
      if (gapQ[i] > maxGap) begin
        maxGap = gapQ[i];
      end
    end
    maxGap = maxGap + MAX_EXTRA;
    cycleLimit = vecQ.size() * (`MAX_LEN + 3 + maxGap) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    // zero matches everywhere right after reset.
    repeat (2) begin
      @(negedge clk);
      checkFlag("afterReset", "busy", 1'b0, busy);
      checkFlag("afterReset", "done", 1'b0, done);
      for (int r = 0; r < `M_ROWS; r++) begin
        checkScore("afterReset", $sformatf("row %0d", r),
                   scoreT'(`MAX_LEN - rowLength(r)), rowScore(r));
      end
    end
    for (int i = 0; i < vecQ.size(); i++) begin
      runTest(i);
    end
    if (vecQ.size() == 0 || checkCount == 0) begin
      $display("the trace held no tests, nothing was checked");
      failAndStop();
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout, the run did not finish within %0d cycles", cycleLimit);
      failAndStop();
    end
  end

endmodule

/* xnorLayer_trace.txt */
// columns: input vector (hex), idle gap in cycles, expected score of rows 0 to 3
// rows have lengths 2, 0, 4 and 4, so row 1 always reads MAX_LEN.
00 3 4 4 4 2
ff 0 4 4 4 6
2f 2 6 4 8 8
d0 1 2 4 0 0
01 0 4 4 6 2
02 4 6 4 4 4
04 1 4 4 4 4
08 0 4 4 6 2
10 2 4 4 2 2
20 3 4 4 4 4
40 0 2 4 4 0
80 1 4 4 2 2
a5 2 4 4 4 6
5a 0 4 4 4 2
3c 4 4 4 4 6
c3 1 4 4 4 2
0f 0 6 4 8 6
f0 2 2 4 0 2
55 3 2 4 4 2
aa 0 6 4 4 6
7e 1 4 4 4 6
81 2 4 4 4 2
2e 0 6 4 6 8
19 4 4 4 6 2
e6 1 4 4 2 6
9b 0 6 4 4 4
64 2 2 4 4 4
37 3 6 4 4 8
c8 0 2 4 4 0
4d 1 2 4 8 2
b2 2 6 4 0 6
00 0 4 4 4 2
2f 1 6 4 8 8
d0 5 2 4 0 0

/* xnorRowAccum.sv */
`timescale 1ns/1ps

`include "xnorLayer_defines.svh"

module xnorRowAccum #(
  parameter int ROW_LEN = 1
) (
  input  logic               clk,
  input  logic               rst,
  accumIf.accum              acc,
  input  logic               matchBit,
  output xnorLayerPkg::scoreT score
);
  import xnorLayerPkg::*;

  // enough bits to count every slot of the longest row.
  localparam int CNT_W = $clog2(`MAX_LEN + 1);

  // constant part of the score.
  localparam scoreT OFFSET = scoreT'(`MAX_LEN - ROW_LEN);

  logic [CNT_W-1:0] matchCnt;
  logic             slotLive;

  // slots past the row length carry no weight.
  assign slotLive = (int'(acc.slot) < ROW_LEN);

  // ********************
  // match counter.
  // ********************
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      matchCnt <= '0;
    end else if (acc.clear) begin
      matchCnt <= '0;
    end else if (acc.step && slotLive && matchBit) begin
      matchCnt <= matchCnt + 1'b1;
    end
  end

  // ********************
  // score correction.
  // ********************
  // a mismatch counts as -1, a match as +1, so
  // sum = 2*matches - ROW_LEN, shifted up by MAX_LEN to stay unsigned.
  assign score = (scoreT'(matchCnt) << 1) + OFFSET;

endmodule

/* xnorSparseMatVec.sv */
`timescale 1ns/1ps

`include "xnorLayer_defines.svh"

module xnorSparseMatVec (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  xnorLayerPkg::inVecT inVec,
  accumIf.accum               acc,
  output xnorLayerPkg::scoreT scores [`M_ROWS]
);
  import xnorLayerPkg::*;

  // ********************
  // weight tables.
  // ********************
  localparam logic [`NNZ-1:0]              SIGNS     = `W_SIGNS;
  localparam logic [`NNZ*8-1:0]            COLS      = `W_COLS;
  localparam logic [(`M_ROWS+1)*8-1:0]     ROW_START = `W_ROWSTART;

  inVecT inReg;

  // input vector, taken only on a start outside the walk.
  always_ff @(posedge clk) begin
    if (start && !acc.step) begin
      inReg <= inVec;
    end
  end

  // ********************
  // rows.
  // ********************
  for (genvar j = 0; j < `M_ROWS; j++) begin : gRow
    localparam int FIRST = ROW_START[j*8 +: 8];
    localparam int LEN   = ROW_START[(j+1)*8 +: 8] - FIRST;

    if (LEN != 0) begin : gLive
      // xnor of weight sign and input bit, one entry per slot.
      logic [`MAX_LEN-1:0] slotMatch;
      logic                matchBit;

      for (genvar i = 0; i < `MAX_LEN; i++) begin : gSlot
        if (i < LEN) begin : gUsed
          localparam int COL = COLS[(FIRST+i)*8 +: 8];

          if (SIGNS[FIRST+i]) begin : gPos
            assign slotMatch[i] = inReg[COL];
          end else begin : gNeg
            assign slotMatch[i] = ~inReg[COL];
          end
        end else begin : gPad
          assign slotMatch[i] = 1'b0;
        end
      end

      // pick the slot being walked.
      assign matchBit = slotMatch[acc.slot];

      xnorRowAccum #(
        .ROW_LEN (LEN)
      ) uAccum (
        .clk      (clk),
        .rst      (rst),
        .acc      (acc),
        .matchBit (matchBit),
        .score    (scores[j])
      );
    end else begin : gEmpty
      // no weights, so the score never moves off its offset.
      assign scores[j] = scoreT'(`MAX_LEN);
    end
  end

endmodule
